/* counter_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module counter_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire counter_pkg::value_t value,
    input  wire counter_pkg::seg_t   seg,
    input  wire counter_pkg::anode_t an
);

    // Current test and its expected step period, 0 means unchecked
    string               test_name = "reset";
    int unsigned         exp_period;
    int                  value_errors;
    int                  period_errors;
    int                  display_errors;
    // Step period tracking
    counter_pkg::value_t last_value;
    int unsigned         since_change;
    logic                seen_change;
    // Scan order tracking
    int                  prev_idx;
    int                  dwell;

    initial
    begin
        exp_period     = 0;
        value_errors   = 0;
        period_errors  = 0;
        display_errors = 0;
        seen_change    = 1'b0;
        since_change   = 0;
    end

    // New test starts, period measurement restarts
    task automatic start_test(input string name, input int unsigned period);
        test_name    = name;
        exp_period   = period;
        seen_change  = 1'b0;
        since_change = 0;
    endtask

    // End of run compare
    task automatic check_value(input counter_pkg::value_t exp);
        if (value !== exp)
        begin
            $display("FAIL %s: expected %h, actual %h", test_name, exp, value);
            value_errors++;
        end
    endtask

    task automatic report(output int total);
        total = value_errors + period_errors + display_errors;
        $display("Errors: value %0d, period %0d, display %0d, total %0d",
                 value_errors, period_errors, display_errors, total);
    endtask

    ////////////////////
    // Step period
    ////////////////////

    // Pre-edge samples, so an update shows one edge later
    always @(posedge clk)
    begin
        if (rst)
        begin
            last_value   = '0;
            seen_change  = 1'b0;
            since_change = 0;
        end
        else
        begin
            since_change++;
            if (value !== last_value)
            begin
                // First change of a test has no reference
                if (seen_change && exp_period != 0 && since_change != exp_period)
                begin
                    $display("FAIL %s period: expected %0d, actual %0d",
                             test_name, exp_period, since_change);
                    period_errors++;
                end
                seen_change  = 1'b1;
                since_change = 0;
                last_value   = value;
            end
        end
    end

    ////////////////////
    // Display scan
    ////////////////////

    always @(posedge clk)
    begin : scan_check
        int                idx;
        counter_pkg::seg_t exp_seg;

        if (rst)
        begin
            prev_idx = 0;
            dwell    = 0;
        end
        else
        begin
            case (an)
                4'b1110: idx = 0;
                4'b1101: idx = 1;
                4'b1011: idx = 2;
                4'b0111: idx = 3;
                default: idx = -1;
            endcase
            if (idx < 0)
            begin
                $display("Anode select %b is not one-hot active low in %s", an, test_name);
                display_errors++;
            end
            else
            begin
                exp_seg = counter_pkg::seg_pattern(value[idx*4 +: 4]);
                if (seg !== exp_seg)
                begin
                    $display("FAIL %s segments: expected %b, actual %b",
                             test_name, exp_seg, seg);
                    display_errors++;
                end
                if (idx == prev_idx)
                begin
                    dwell++;
                end
                else
                begin
                    if (idx != (prev_idx + 1) % 4)
                    begin
                        $display("Digit %0d followed digit %0d out of order in %s",
                                 idx, prev_idx, test_name);
                        display_errors++;
                    end
                    if (dwell != 4)
                    begin
                        $display("FAIL %s dwell: expected 4, actual %0d", test_name, dwell);
                        display_errors++;
                    end
                    dwell    = 1;
                    prev_idx = idx;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* counter_pkg.sv */
`default_nettype none

package counter_pkg;

    // Widths shared by the divider, the counter and the display
    typedef logic [4:0]  rate_sel_t;
    typedef logic [31:0] count_t;
    typedef logic [3:0]  digit_t;
    // Digit 0 sits in the low nibble
    typedef logic [15:0] value_t;
    // Active low, bit 6 is segment g and bit 0 is segment a
    typedef logic [6:0]  seg_t;
    // Active low digit enables
    typedef logic [3:0]  anode_t;

    // Seven-segment pattern for one hex digit
    function automatic seg_t seg_pattern(input digit_t digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            // Letters shown as A b C d E F
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

`default_nettype wire

/* counter_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module counter_tb;

    logic                   clk;
    logic                   rst;
    counter_pkg::rate_sel_t rate_sel;
    logic                   hex_mode;
    logic                   count_up;
    logic                   enable;
    logic                   clear;
    counter_pkg::value_t    value;
    counter_pkg::seg_t      seg;
    counter_pkg::anode_t    an;

    // Trace columns, one entry per line
    string               names[$];
    int                  sel_q[$];
    int                  hex_q[$];
    int                  up_q[$];
    int                  en_q[$];
    int                  clr_q[$];
    int                  len_q[$];
    int                  per_q[$];
    counter_pkg::value_t exp_q[$];
    int                  total_cycles;
    logic                trace_loaded;
    int                  failures;
    logic                trace_ok;

    counter_top #(
        .TICK_UNIT   (1),
        .SCAN_CYCLES (4)
    ) u_counter_top (
        .clk      (clk),
        .rst      (rst),
        .rate_sel (rate_sel),
        .hex_mode (hex_mode),
        .count_up (count_up),
        .enable   (enable),
        .clear    (clear),
        .value    (value),
        .seg      (seg),
        .an       (an)
    );

    counter_checker u_counter_checker (
        .clk   (clk),
        .rst   (rst),
        .value (value),
        .seg   (seg),
        .an    (an)
    );

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Trace reader
    ////////////////////

    task automatic load_trace(output logic ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        int          sel, hx, up, en, clr, len, per;
        logic [15:0] exp;

        ok = 1'b0;
        fd = $fopen("counter_trace.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                // Comment lines start with a hash
                if (n > 0 && line.len() > 0 && line.getc(0) != 8'h23)
                begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %h",
                                name, sel, hx, up, en, clr, len, per, exp);
                    if (n == 9)
                    begin
                        names.push_back(name);
                        sel_q.push_back(sel);
                        hex_q.push_back(hx);
                        up_q.push_back(up);
                        en_q.push_back(en);
                        clr_q.push_back(clr);
                        len_q.push_back(len);
                        per_q.push_back(per);
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
            ok = (names.size() > 0);
        end
    endtask

    // Settings change on the falling edge
    task automatic run_tests();
        for (int i = 0; i < names.size(); i++)
        begin
            rate_sel = counter_pkg::rate_sel_t'(sel_q[i]);
            hex_mode = hex_q[i][0];
            count_up = up_q[i][0];
            enable   = en_q[i][0];
            clear    = clr_q[i][0];
            u_counter_checker.start_test(names[i], per_q[i]);
            repeat (len_q[i]) @(negedge clk);
            u_counter_checker.check_value(exp_q[i]);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        rst          = 1'b1;
        rate_sel     = 5'd31;
        hex_mode     = 1'b0;
        count_up     = 1'b1;
        enable       = 1'b0;
        clear        = 1'b0;
        trace_loaded = 1'b0;
        total_cycles = 0;
        failures     = 0;
        load_trace(trace_ok);
        if (!trace_ok)
        begin
            $display("Trace file counter_trace.txt is missing or holds no test lines");
            $display("Test failures found");
            $finish;
        end
        else
        begin
            foreach (len_q[i])
                total_cycles += len_q[i];
            trace_loaded = 1'b1;
            // Two cycles of reset
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            run_tests();
            u_counter_checker.report(failures);
            if (failures == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

    // Run length sum plus margin
    initial
    begin
        wait (trace_loaded === 1'b1);
        #((total_cycles + 200) * 40);
        $display("Timeout after %0d cycles, the run did not reach its end",
                 total_cycles + 200);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* counter_top.sv */
`timescale 1ns/100ps
`default_nettype none

module counter_top #(
    // 10000 for board rates, 1 for short runs
    parameter int unsigned TICK_UNIT   = 10000,
    // About 1 ms per digit at 100 MHz
    parameter int unsigned SCAN_CYCLES = 100000
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire counter_pkg::rate_sel_t rate_sel,
    input  wire                         hex_mode,
    input  wire                         count_up,
    input  wire                         enable,
    input  wire                         clear,
    output wire counter_pkg::value_t    value,
    output wire counter_pkg::seg_t      seg,
    output wire counter_pkg::anode_t    an
);

    // One cycle strobe per divider period
    logic step;

    ////////////////////
    // Step generation
    ////////////////////

    rate_divider #(
        .TICK_UNIT (TICK_UNIT)
    ) u_rate_divider (
        .clk      (clk),
        .rst      (rst),
        .rate_sel (rate_sel),
        .step     (step)
    );

    // Count register, new value one cycle after the step
    digit_counter u_digit_counter (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .enable   (enable),
        .clear    (clear),
        .hex_mode (hex_mode),
        .count_up (count_up),
        .value    (value)
    );

    ////////////////////
    // Display
    ////////////////////

    display_scan #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) u_display_scan (
        .clk   (clk),
        .rst   (rst),
        .value (value),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire

/* counter_trace.txt */
# Columns: name rate_sel hex_mode count_up enable clear cycles period expected_hex
# period is table multiple plus 1, 0 skips the period check
# Fastest rate, BCD up, one step every 3 cycles
bcd_up_first      31 0 1 1 0 30    3 0010
bcd_up_carry      31 0 1 1 0 300   3 0110
bcd_up_top        31 0 1 1 0 29667 3 9999
bcd_wrap          31 0 1 1 0 3     3 0000

# Hex down through zero
hex_down_wrap     31 1 0 1 0 3     3 ffff
hex_down_more     31 1 0 1 0 6     3 fffd

# Clear while steps arrive
clear_stepping    31 1 0 1 1 1     0 0000
clear_hold        31 1 0 1 1 9     0 0000

# Hex up through 00ff
hex_up_00ff       31 1 1 1 0 765   3 00ff
hex_up_carry      31 1 1 1 0 3     3 0100
enable_low_hold   31 1 1 0 0 40    0 0100

# Slower rate, then back to the fastest with the count above its limit
period_sel24      24 1 1 1 0 105   10 010a
fast_switch       31 1 1 1 0 2     0 010b
period_sel31      31 1 1 1 0 30    3 0115

# BCD down with borrow, then a final clear
bcd_down_borrow   31 0 0 1 0 18    3 0109
clear_final       31 0 0 1 1 1     0 0000

/* digit_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_counter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 step,
    input  wire                 enable,
    input  wire                 clear,
    input  wire                 hex_mode,
    input  wire                 count_up,
    output counter_pkg::value_t value
);

    ////////////////////
    // Next value
    ////////////////////

    // Highest digit before the wrap
    counter_pkg::digit_t digit_max;
    // Value after one count in the current direction
    counter_pkg::value_t next_value;

    assign digit_max = hex_mode ? 4'hF : 4'h9;

    // Ripple carry or borrow from digit 0 up to digit 3
    always_comb
    begin : ripple
        counter_pkg::digit_t cur;
        logic                carry;

        next_value = value;
        // The step itself enters as a carry into digit 0
        carry = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            cur = value[i*4 +: 4];
            if (carry)
            begin
                if (count_up)
                begin
                    if (cur >= digit_max)
                    begin
                        // Wrap to 0 and pass the carry on
                        next_value[i*4 +: 4] = 4'h0;
                    end
                    else
                    begin
                        next_value[i*4 +: 4] = cur + 4'h1;
                        carry = 1'b0;
                    end
                end
                else
                begin
                    if (cur == 4'h0)
                    begin
                        // Borrow from the next digit
                        next_value[i*4 +: 4] = digit_max;
                    end
                    else
                    begin
                        next_value[i*4 +: 4] = cur - 4'h1;
                        carry = 1'b0;
                    end
                end
            end
        end
        // Carry out of digit 3 is dropped, so the whole value wraps
    end

    ////////////////////
    // Value register
    ////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value <= '0;
        end
        else if (clear)
        begin
            // Clear wins over a pending step
            value <= '0;
        end
        else if (step && enable)
        begin
            value <= next_value;
        end
    end

endmodule

`default_nettype wire

/* display_scan.sv */
`timescale 1ns/100ps
`default_nettype none

module display_scan #(
    // Cycles each digit stays lit
    parameter int unsigned SCAN_CYCLES = 100000
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire counter_pkg::value_t value,
    output counter_pkg::seg_t        seg,
    output counter_pkg::anode_t      an
);

    ////////////////////
    // Refresh timing
    ////////////////////

    // Cycles spent on the current digit
    counter_pkg::count_t refresh_cnt;
    // Digit being shown
    logic [1:0]          digit_idx;
    // Last cycle of the current digit
    logic                advance;

    assign advance = (refresh_cnt >= counter_pkg::count_t'(SCAN_CYCLES - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            refresh_cnt <= '0;
        end
        else if (advance)
        begin
            refresh_cnt <= '0;
        end
        else
        begin
            refresh_cnt <= refresh_cnt + 32'd1;
        end
    end

    // Order 0 1 2 3 then back to 0 by natural overflow
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit_idx <= 2'd0;
        end
        else if (advance)
        begin
            digit_idx <= digit_idx + 2'd1;
        end
    end

    ////////////////////
    // Digit mux and decode
    ////////////////////

    // Nibble selected by the scan index
    counter_pkg::digit_t shown_digit;

    assign shown_digit = value[{digit_idx, 2'b00} +: 4];

    // One-hot, active low
    assign an = ~(counter_pkg::anode_t'(4'b0001) << digit_idx);

    // Follows value within the same cycle
    assign seg = counter_pkg::seg_pattern(shown_digit);

endmodule

`default_nettype wire

/* rate_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module rate_divider #(
    // Base unit of the rate table in clk cycles
    parameter int unsigned TICK_UNIT = 10000
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire counter_pkg::rate_sel_t rate_sel,
    output logic                        step
);

    ////////////////////
    // Rate table
    ////////////////////

    // Table entry in units of TICK_UNIT
    counter_pkg::count_t multiple;
    // Cycle count at which the step fires
    counter_pkg::count_t limit;
    // Free running cycle counter
    counter_pkg::count_t cycle_cnt;

    // Slowest rate first
    always_comb
    begin
        case (rate_sel)
            5'd0:    multiple = 32'd100000;
            5'd1:    multiple = 32'd5000;
            5'd2:    multiple = 32'd4000;
            5'd3:    multiple = 32'd3000;
            5'd4:    multiple = 32'd2000;
            5'd5:    multiple = 32'd1000;
            // Hundreds
            5'd6:    multiple = 32'd900;
            5'd7:    multiple = 32'd800;
            5'd8:    multiple = 32'd700;
            5'd9:    multiple = 32'd600;
            5'd10:   multiple = 32'd500;
            5'd11:   multiple = 32'd400;
            5'd12:   multiple = 32'd300;
            5'd13:   multiple = 32'd200;
            5'd14:   multiple = 32'd100;
            // Tens
            5'd15:   multiple = 32'd90;
            5'd16:   multiple = 32'd80;
            5'd17:   multiple = 32'd70;
            5'd18:   multiple = 32'd60;
            5'd19:   multiple = 32'd50;
            5'd20:   multiple = 32'd40;
            5'd21:   multiple = 32'd30;
            5'd22:   multiple = 32'd20;
            5'd23:   multiple = 32'd10;
            // Units
            5'd24:   multiple = 32'd9;
            5'd25:   multiple = 32'd8;
            5'd26:   multiple = 32'd7;
            5'd27:   multiple = 32'd6;
            5'd28:   multiple = 32'd5;
            5'd29:   multiple = 32'd4;
            5'd30:   multiple = 32'd3;
            // Select 31 is the fastest rate
            default: multiple = 32'd2;
        endcase
    end

    // Largest entry times 10000 still fits in 32 bits
    assign limit = multiple * counter_pkg::count_t'(TICK_UNIT);

    ////////////////////
    // Cycle counter
    ////////////////////

    // Reached or passed the limit, so one strobe and a restart
    // Also catches a switch to a faster rate mid period
    assign step = (cycle_cnt >= limit);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cycle_cnt <= '0;
        end
        else if (step)
        begin
            // Restart after the strobe cycle
            cycle_cnt <= '0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, result decided from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module counter_tb -f src.f -o counter_sim \
    && ./obj_dir/counter_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

/* src.f */
counter_pkg.sv
rate_divider.sv
digit_counter.sv
display_scan.sv
counter_top.sv
counter_checker.sv
counter_tb.sv
